// File: compile.f
+incdir+design
design/iotdf_data_pkg.sv
design/iotdf_ctrl_pkg.sv
design/word_loader.sv
design/crc3_engine.sv
design/extremum_tracker.sv
design/result_selector.sv
design/iotdf_top.sv
verif/iotdf_clkgen.sv
verif/iotdf_asserts.sv
verif/iotdf_tb.sv

// File: run.sh
#!/bin/sh
# build and run with Verilator, fail if the log reports failure
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f --top-module iotdf_tb \
  -o iotdf_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/iotdf_sim > sim.log 2>&1 \
  || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && exit 1 || exit 0

// File: verif/iotdf_tb.sv
`timescale 1ns/1ns

module iotdf_tb
  import iotdf_ctrl_pkg::*;
();

  logic         clk;
  logic         rst;
  logic         i_in_en;
  logic [7:0]   i_iot_in;
  fn_sel_t      i_fn_sel;
  logic         o_valid;
  logic [127:0] o_iot_out;

  int           cyc = 0;
  int           err_data = 0;
  int           err_proto = 0;
  logic [31:0]  rng;
  logic [7:0]   grp [0:127];

  // expected result beats keyed by the cycle they should show up in
  int           exp_cyc_q [$];
  logic [127:0] exp_data_q [$];

  iotdf_clkgen u_iotdf_clkgen (
    .o_clk (clk)
  );

  iotdf_top u_iotdf_top (
    .clk       (clk),
    .rst       (rst),
    .i_in_en   (i_in_en),
    .i_iot_in  (i_iot_in),
    .i_fn_sel  (i_fn_sel),
    .o_valid   (o_valid),
    .o_iot_out (o_iot_out)
  );

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [127:0] word_at(input int k);
    logic [127:0] w;
    for (int b = 0; b < 16; b++) begin
      w[b*8 +: 8] = grp[k*16 + b];
    end
    return w;
  endfunction

  // message times x^3 divided by x^3+x+1 with bytes msb first
  function automatic logic [2:0] crc_model();
    logic [3:0] r;
    r = 4'd0;
    for (int n = 0; n < 128 * 8 + 3; n++) begin
      r = {r[2:0], (n < 1024) ? grp[n / 8][7 - (n % 8)] : 1'b0};
      if (r[3]) begin
        r = r ^ 4'b1011;
      end
    end
    return r[2:0];
  endfunction

  // best and runner-up of the eight words with duplicates counted twice
  task automatic pick_two(input logic want_max, output logic [127:0] best,
                          output logic [127:0] next);
    int bi;
    logic [127:0] w;
    bi = 0;
    for (int k = 1; k < 8; k++) begin
      w = word_at(k);
      if (want_max ? (w > word_at(bi)) : (w < word_at(bi))) bi = k;
    end
    best = word_at(bi);
    next = want_max ? '0 : '1;
    for (int k = 0; k < 8; k++) begin
      w = word_at(k);
      if (k != bi && (want_max ? (w > next) : (w < next))) next = w;
    end
  endtask

  task automatic fill_group(input logic dup_max);
    for (int n = 0; n < 128; n++) begin
      rng = lcg_next(rng);
      grp[n] = rng[23:16];
    end
    if (dup_max) begin
      // two equal words sit clearly above the rest
      for (int k = 0; k < 8; k++) grp[k*16 + 15][7] = 1'b0;
      grp[3*16 + 15] = 8'hff;
      for (int b = 0; b < 16; b++) grp[6*16 + b] = grp[3*16 + b];
    end
  endtask

  task automatic end_run();
    $display("errors: data=%0d protocol=%0d", err_data, err_proto);
    if (err_data == 0 && err_proto == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  // entered and left 1 ns after a rising edge
  task automatic send_group(input fn_sel_t mode, input int gap_pct, input logic dup_max);
    int acc;
    int gaps;
    logic [127:0] best;
    logic [127:0] next;
    fill_group(dup_max);
    i_fn_sel = mode;
    acc = 0;
    for (int n = 0; n < 128; n++) begin
      gaps = 0;
      rng = lcg_next(rng);
      while (rng[30:24] % 100 < gap_pct && gaps < 3) begin
        i_in_en = 1'b0;
        @(posedge clk);
        #1;
        gaps++;
        rng = lcg_next(rng);
      end
      i_in_en  = 1'b1;
      i_iot_in = grp[n];
      acc = cyc + 1;
      @(posedge clk);
      #1;
    end
    i_in_en = 1'b0;
    // first beat is seen before edge acc+3
    if (mode == FN_CRC_GEN) begin
      exp_cyc_q.push_back(acc + 2);
      exp_data_q.push_back({125'd0, crc_model()});
    end else if (mode == FN_TOP2MAX || mode == FN_LAST2MIN) begin
      pick_two(mode == FN_TOP2MAX, best, next);
      exp_cyc_q.push_back(acc + 2);
      exp_data_q.push_back(best);
      exp_cyc_q.push_back(acc + 3);
      exp_data_q.push_back(next);
    end
  endtask

  task automatic drain();
    int t;
    t = 0;
    while (exp_cyc_q.size() > 0 && t < 300) begin
      @(posedge clk);
      t++;
    end
    #1;
    if (exp_cyc_q.size() > 0) begin
      $display("timed out waiting for o_valid, %0d beats missing", exp_cyc_q.size());
      err_proto++;
      exp_cyc_q.delete();
      exp_data_q.delete();
    end
  endtask

  // outputs sampled mid-cycle
  always @(negedge clk) begin
    if (cyc >= 1) begin
      if (o_valid) begin
        if (exp_cyc_q.size() == 0) begin
          $display("o_valid high at cycle %0d with no result pending", cyc);
          err_proto++;
        end else begin
          chk_beat_cycle: assert (exp_cyc_q[0] == cyc) else begin
            $display("result beat at cycle %0d, expected at %0d", cyc, exp_cyc_q[0]);
            err_proto++;
          end
          chk_beat_data: assert (o_iot_out === exp_data_q[0]) else begin
            $display("ERR o_iot_out exp %h got %h", exp_data_q[0], o_iot_out);
            err_data++;
          end
          void'(exp_cyc_q.pop_front());
          void'(exp_data_q.pop_front());
        end
      end else begin
        chk_idle_out: assert (o_iot_out === 128'd0) else begin
          $display("ERR o_iot_out exp %h got %h", 128'd0, o_iot_out);
          err_data++;
        end
        if (exp_cyc_q.size() > 0 && exp_cyc_q[0] <= cyc) begin
          $display("result beat due at cycle %0d never came", exp_cyc_q[0]);
          err_proto++;
          void'(exp_cyc_q.pop_front());
          void'(exp_data_q.pop_front());
        end
      end
    end
  end

  initial begin
    rst      = 1'b1;
    i_in_en  = 1'b0;
    i_iot_in = 8'h00;
    i_fn_sel = FN_IDLE;
    rng      = 32'h84bfc2d0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    // idle and reserved codes give no output
    send_group(FN_IDLE, 10, 1'b0);
    send_group(fn_sel_t'(3'd1), 0, 1'b0);
    drain();
    repeat (3) send_group(FN_CRC_GEN, 25, 1'b0);
    drain();
    send_group(FN_TOP2MAX, 15, 1'b0);
    send_group(FN_TOP2MAX, 0, 1'b1);
    drain();
    repeat (2) send_group(FN_LAST2MIN, 20, 1'b0);
    drain();
    // back to back with mode changes
    send_group(FN_CRC_GEN, 0, 1'b0);
    send_group(FN_TOP2MAX, 0, 1'b0);
    send_group(FN_LAST2MIN, 0, 1'b0);
    send_group(FN_CRC_GEN, 0, 1'b0);
    send_group(FN_TOP2MAX, 0, 1'b1);
    drain();
    send_group(FN_IDLE, 0, 1'b0);
    repeat (8) @(posedge clk);
    #1;
    drain();
    end_run();
  end

endmodule

// File: verif/iotdf_asserts.sv
`timescale 1ns/1ns

module iotdf_asserts
  import iotdf_ctrl_pkg::*;
(
  input logic    clk,
  input logic    rst,
  input fn_sel_t i_fn_sel,
  input logic    o_valid
);

  // a beat seen at an edge was launched by the mode sampled 3 edges
  // before it, or 4 for the runner-up beat
  function automatic logic is_ext(fn_sel_t f);
    return (f == FN_TOP2MAX) || (f == FN_LAST2MIN);
  endfunction

  no_valid_in_reset: assert property (
    @(posedge clk) rst |-> !o_valid
  ) else $error("o_valid high during reset");

  no_valid_when_idle: assert property (
    @(posedge clk) disable iff (rst)
    ($past(i_fn_sel, 3) == FN_IDLE && $past(i_fn_sel, 4) == FN_IDLE) |-> !o_valid
  ) else $error("o_valid high in idle mode");

  crc_single_beat: assert property (
    @(posedge clk) disable iff (rst)
    (o_valid && $past(i_fn_sel, 3) == FN_CRC_GEN) |=> !o_valid
  ) else $error("crc result longer than one beat");

  ext_two_beats: assert property (
    @(posedge clk) disable iff (rst)
    ($rose(o_valid) && is_ext($past(i_fn_sel, 3))) |=> o_valid ##1 !o_valid
  ) else $error("extremum result not exactly two beats");

endmodule

bind iotdf_top iotdf_asserts u_iotdf_asserts (
  .clk      (clk),
  .rst      (rst),
  .i_fn_sel (i_fn_sel),
  .o_valid  (o_valid)
);

// File: verif/iotdf_clkgen.sv
`timescale 1ns/1ns

module iotdf_clkgen (
  output logic o_clk
);

  // 4 ns period
  initial begin
    o_clk = 1'b0;
  end

  always #2 o_clk = ~o_clk;

endmodule

// File: design/iotdf_top.sv
`timescale 1ns/1ns

module iotdf_top
  import iotdf_data_pkg::*;
  import iotdf_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      i_in_en,
  input  iot_byte_t i_iot_in,
  input  fn_sel_t   i_fn_sel,
  output logic      o_valid,
  output iot_word_t o_iot_out
);

  // loader to engines
  logic      byte_vld;
  iot_byte_t byte_data;
  logic      group_first;
  logic      group_last;
  logic      word_vld;
  iot_word_t word_data;
  word_idx_t word_idx;

  // engines to selector
  logic      crc_vld;
  crc3_t     crc;
  logic      ext_vld;
  iot_word_t ext_first;
  iot_word_t ext_second;

  word_loader u_word_loader (
    .clk           (clk),
    .rst           (rst),
    .i_in_en       (i_in_en),
    .i_iot_in      (i_iot_in),
    .o_byte_vld    (byte_vld),
    .o_byte        (byte_data),
    .o_group_first (group_first),
    .o_group_last  (group_last),
    .o_word_vld    (word_vld),
    .o_word        (word_data),
    .o_word_idx    (word_idx)
  );

  crc3_engine u_crc3_engine (
    .clk           (clk),
    .rst           (rst),
    .i_byte_vld    (byte_vld),
    .i_byte        (byte_data),
    .i_group_first (group_first),
    .i_group_last  (group_last),
    .o_crc_vld     (crc_vld),
    .o_crc         (crc)
  );

  extremum_tracker u_extremum_tracker (
    .clk          (clk),
    .rst          (rst),
    .i_fn_sel     (i_fn_sel),
    .i_word_vld   (word_vld),
    .i_word       (word_data),
    .i_word_idx   (word_idx),
    .o_ext_vld    (ext_vld),
    .o_ext_first  (ext_first),
    .o_ext_second (ext_second)
  );

  result_selector u_result_selector (
    .clk          (clk),
    .rst          (rst),
    .i_fn_sel     (i_fn_sel),
    .i_crc_vld    (crc_vld),
    .i_crc        (crc),
    .i_ext_vld    (ext_vld),
    .i_ext_first  (ext_first),
    .i_ext_second (ext_second),
    .o_valid      (o_valid),
    .o_iot_out    (o_iot_out)
  );

endmodule

// File: design/result_selector.sv
`timescale 1ns/1ns
`include "iotdf_consts.svh"

module result_selector
  import iotdf_data_pkg::*;
  import iotdf_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  fn_sel_t   i_fn_sel,
  input  logic      i_crc_vld,
  input  crc3_t     i_crc,
  input  logic      i_ext_vld,
  input  iot_word_t i_ext_first,
  input  iot_word_t i_ext_second,
  output logic      o_valid,
  output iot_word_t o_iot_out
);

  fn_sel_t fn_d1;
  fn_sel_t fn_d2;
  logic    crc_hit;
  logic    ext_hit;
  logic    beat2_q;

  // engine strobes come two cycles after the last byte, so gate them
  // with the mode seen on that byte
  assign crc_hit = i_crc_vld && (fn_d2 == FN_CRC_GEN);
  assign ext_hit = i_ext_vld && (fn_d2 == FN_TOP2MAX || fn_d2 == FN_LAST2MIN);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fn_d1     <= FN_IDLE;
      fn_d2     <= FN_IDLE;
      beat2_q   <= 1'b0;
      o_valid   <= 1'b0;
      o_iot_out <= '0;
    end else begin
      fn_d1 <= i_fn_sel;
      fn_d2 <= fn_d1;
      if (crc_hit) begin
        o_valid   <= 1'b1;
        o_iot_out <= iot_word_t'(i_crc);
      end else if (ext_hit) begin
        o_valid   <= 1'b1;
        o_iot_out <= i_ext_first;
        beat2_q   <= 1'b1;
      end else if (beat2_q) begin
        // runner-up beat
        o_valid   <= 1'b1;
        o_iot_out <= i_ext_second;
        beat2_q   <= 1'b0;
      end else begin
        o_valid   <= 1'b0;
        o_iot_out <= '0;
      end
    end
  end

endmodule

// File: design/extremum_tracker.sv
`timescale 1ns/1ns
`include "iotdf_consts.svh"

module extremum_tracker
  import iotdf_data_pkg::*;
  import iotdf_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  fn_sel_t   i_fn_sel,
  input  logic      i_word_vld,
  input  iot_word_t i_word,
  input  word_idx_t i_word_idx,
  output logic      o_ext_vld,
  output iot_word_t o_ext_first,
  output iot_word_t o_ext_second
);

  trk_state_t state_q;
  trk_state_t state_nxt;
  iot_word_t  first_q;
  iot_word_t  second_q;
  logic       dir_max_q;
  logic       is_max_now;
  logic       start;
  logic       take_first;
  logic       take_second;

  // strict compare, so equal words fall through to the runner-up
  function automatic logic beats(iot_word_t a, iot_word_t b, logic want_max);
    return want_max ? (a > b) : (a < b);
  endfunction

  assign is_max_now  = (i_fn_sel == FN_TOP2MAX);
  assign start       = i_word_vld && (i_word_idx == '0) &&
                       (is_max_now || (i_fn_sel == FN_LAST2MIN));
  assign take_first  = beats(i_word, first_q, dir_max_q);
  assign take_second = beats(i_word, second_q, dir_max_q);

  always_comb begin
    state_nxt = state_q;
    case (state_q)
      TRK_IDLE: if (start) state_nxt = TRK_CALC;
      TRK_CALC: begin
        if (i_word_vld && i_word_idx == word_idx_t'(`IOTDF_WORDS_PER_GROUP - 1)) begin
          state_nxt = TRK_EMIT;
        end
      end
      default: state_nxt = start ? TRK_CALC : TRK_IDLE;
    endcase
  end

  // direction is fixed for the group at word 0
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q   <= TRK_IDLE;
      dir_max_q <= 1'b0;
    end else begin
      state_q <= state_nxt;
      if (start) begin
        dir_max_q <= is_max_now;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      first_q  <= i_word;
      second_q <= is_max_now ? '0 : '1;
    end else if (state_q == TRK_CALC && i_word_vld) begin
      if (take_first) begin
        second_q <= first_q;
        first_q  <= i_word;
      end else if (take_second) begin
        second_q <= i_word;
      end
    end
  end

  assign o_ext_vld    = (state_q == TRK_EMIT);
  assign o_ext_first  = first_q;
  assign o_ext_second = second_q;

endmodule

// File: design/crc3_engine.sv
`timescale 1ns/1ns
`include "iotdf_consts.svh"

module crc3_engine
  import iotdf_data_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      i_byte_vld,
  input  iot_byte_t i_byte,
  input  logic      i_group_first,
  input  logic      i_group_last,
  output logic      o_crc_vld,
  output crc3_t     o_crc
);

  crc3_t rem_q;
  crc3_t rem_seed;
  crc3_t rem_next;

  // long division by the polynomial, one message bit per step, msb first
  function automatic crc3_t crc_step(crc3_t rem, iot_byte_t data);
    crc3_t r;
    logic  fb;
    r = rem;
    for (int i = `IOTDF_BYTE_W - 1; i >= 0; i--) begin
      fb = r[`IOTDF_CRC_W-1] ^ data[i];
      r  = {r[`IOTDF_CRC_W-2:0], 1'b0};
      if (fb) begin
        r = r ^ `IOTDF_CRC_POLY;
      end
    end
    return r;
  endfunction

  // a new group restarts from zero
  assign rem_seed = i_group_first ? '0 : rem_q;
  assign rem_next = crc_step(rem_seed, i_byte);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rem_q     <= '0;
      o_crc_vld <= 1'b0;
    end else begin
      o_crc_vld <= i_byte_vld && i_group_last;
      if (i_byte_vld) begin
        rem_q <= rem_next;
      end
    end
  end

  // final remainder sits in rem_q when the strobe is out
  assign o_crc = rem_q;

endmodule

// File: design/word_loader.sv
`timescale 1ns/1ns
`include "iotdf_consts.svh"

module word_loader
  import iotdf_data_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      i_in_en,
  input  iot_byte_t i_iot_in,
  output logic      o_byte_vld,
  output iot_byte_t o_byte,
  output logic      o_group_first,
  output logic      o_group_last,
  output logic      o_word_vld,
  output iot_word_t o_word,
  output word_idx_t o_word_idx
);

  logic [3:0] byte_cnt;
  word_idx_t  word_cnt;
  iot_word_t  word_q;
  logic       last_lane;
  logic       last_word;

  assign last_lane = (byte_cnt == 4'(`IOTDF_BYTES_PER_WORD - 1));
  assign last_word = (word_cnt == word_idx_t'(`IOTDF_WORDS_PER_GROUP - 1));

  // counters and strobes, all one cycle behind the accepting edge
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      byte_cnt      <= '0;
      word_cnt      <= '0;
      o_byte_vld    <= 1'b0;
      o_group_first <= 1'b0;
      o_group_last  <= 1'b0;
      o_word_vld    <= 1'b0;
      o_word_idx    <= '0;
    end else begin
      o_byte_vld    <= i_in_en;
      o_group_first <= i_in_en && (byte_cnt == 4'd0) && (word_cnt == '0);
      o_group_last  <= i_in_en && last_lane && last_word;
      o_word_vld    <= i_in_en && last_lane;
      if (i_in_en) begin
        byte_cnt <= last_lane ? 4'd0 : byte_cnt + 4'd1;
        if (last_lane) begin
          // index of the word that just filled
          o_word_idx <= word_cnt;
          word_cnt   <= word_cnt + word_idx_t'(1);
        end
      end
    end
  end

  // first byte lands in bits 7:0, sixteenth in 127:120
  always_ff @(posedge clk) begin
    if (i_in_en) begin
      o_byte <= i_iot_in;
      word_q[byte_cnt*`IOTDF_BYTE_W +: `IOTDF_BYTE_W] <= i_iot_in;
    end
  end

  assign o_word = word_q;

endmodule

// File: design/iotdf_ctrl_pkg.sv
package iotdf_ctrl_pkg;

  // function select, codes 1 and 2 are reserved and act as idle
  typedef enum logic [2:0] {
    FN_IDLE     = 3'd0,
    FN_CRC_GEN  = 3'd3,
    FN_TOP2MAX  = 3'd4,
    FN_LAST2MIN = 3'd5
  } fn_sel_t;

  // extremum tracker states
  typedef enum logic [1:0] {
    TRK_IDLE,
    TRK_CALC,
    TRK_EMIT
  } trk_state_t;

endpackage

// File: design/iotdf_data_pkg.sv
`include "iotdf_consts.svh"

package iotdf_data_pkg;

  // one input byte and one packed word
  typedef logic [`IOTDF_BYTE_W-1:0] iot_byte_t;
  typedef logic [`IOTDF_WORD_W-1:0] iot_word_t;

  // crc remainder, word position in a group
  typedef logic [`IOTDF_CRC_W-1:0] crc3_t;
  typedef logic [2:0] word_idx_t;

endpackage

// File: design/iotdf_consts.svh
`ifndef IOTDF_CONSTS_SVH
`define IOTDF_CONSTS_SVH

// group framing
`define IOTDF_BYTES_PER_WORD 16
`define IOTDF_WORDS_PER_GROUP 8

// data widths
`define IOTDF_BYTE_W 8
`define IOTDF_WORD_W 128
`define IOTDF_CRC_W 3

// x^3 + x + 1, leading term implied
`define IOTDF_CRC_POLY 3'b011

`endif
